// ==== hw/eeprom_pkg.sv ====
package eeprom_pkg;

    // byte address inside the 2 KB array
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] ee_byte_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } ee_op_e;

    // register block to sequencer
    typedef struct packed {
        ee_op_e   op;
        ee_addr_t addr;
        ee_byte_t wdata;
    } ee_req_t;

    typedef struct packed {
        ee_byte_t rdata;
        logic     nack;   // some written byte was not acknowledged
    } ee_rsp_t;

    typedef enum logic [1:0] {
        BIT_START = 2'd0,
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,
        BIT_READ  = 2'd3
    } bit_cmd_e;

    // sequencer to bit engine
    typedef struct packed {
        bit_cmd_e cmd;
        ee_byte_t tx;
        logic     ack;    // read only, 1 pulls sda low in the ack slot
    } bit_req_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_WR,
        SEQ_ADDR_WR,
        SEQ_DATA_WR,
        SEQ_READ_START,
        SEQ_CTRL_RD,
        SEQ_DATA_RD,
        SEQ_STOP,
        SEQ_DONE
    } seq_state_e;

    localparam logic [7:0] REG_CMD    = 8'h00;
    localparam logic [7:0] REG_ADDR   = 8'h04;
    localparam logic [7:0] REG_WDATA  = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;
    localparam logic [7:0] REG_RDATA  = 8'h10;

    localparam logic [3:0] DEV_CODE = 4'b1010;   // 24Cxx family

endpackage

// ==== hw/eeprom_apb_regs.sv ====
`timescale 1ns/10ps

module eeprom_apb_regs import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        req_valid,
    output ee_req_t     req,
    input  logic        busy,
    input  logic        rsp_valid,
    input  ee_rsp_t     rsp
);

    ee_addr_t addr_q;
    ee_byte_t wdata_q;
    ee_byte_t rdata_q;
    logic     done_q;
    logic     nack_q;
    logic     access;
    logic     mapped;
    logic     cmd_wr;
    logic     cmd_busy;
    logic     cmd_start;

    assign access    = psel & penable;
    assign mapped    = paddr inside {REG_CMD, REG_ADDR, REG_WDATA, REG_STATUS, REG_RDATA};
    assign cmd_busy  = busy | req_valid;   // req not yet taken by the sequencer
    assign cmd_wr    = access & pwrite & (paddr == REG_CMD);
    assign cmd_start = cmd_wr & ~cmd_busy & (pwdata[1:0] != 2'b00);

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access & (~mapped | (cmd_wr & cmd_busy));

    always_comb begin
        prdata = '0;
        if (psel & ~pwrite) begin
            case (paddr)
                REG_ADDR:   prdata[10:0] = addr_q;
                REG_WDATA:  prdata[7:0]  = wdata_q;
                REG_STATUS: prdata[2:0]  = {nack_q, done_q, cmd_busy};
                REG_RDATA:  prdata[7:0]  = rdata_q;
                default:    prdata       = '0;   // cmd reads back as zero
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (access & pwrite & (paddr == REG_ADDR)) begin
            addr_q <= pwdata[10:0];
        end
        if (access & pwrite & (paddr == REG_WDATA)) begin
            wdata_q <= pwdata[7:0];
        end
        if (rsp_valid) begin
            rdata_q <= rsp.rdata;
        end
        if (cmd_start) begin
            req.op    <= pwdata[0] ? OP_WRITE : OP_READ;   // write wins
            req.addr  <= addr_q;
            req.wdata <= wdata_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            req_valid <= 1'b0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
        end else begin
            req_valid <= cmd_start;
            if (cmd_start) begin
                done_q <= 1'b0;
                nack_q <= 1'b0;
            end else if (rsp_valid) begin
                done_q <= 1'b1;   // sticky until next command
                nack_q <= rsp.nack;
            end
        end
    end

endmodule

// ==== hw/eeprom_seq.sv ====
`timescale 1ns/10ps

module eeprom_seq import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     req_valid,
    input  ee_req_t  req,
    output logic     busy,
    output logic     rsp_valid,
    output ee_rsp_t  rsp,
    output logic     bit_valid,
    output bit_req_t bit_req,
    input  logic     bit_done,
    input  ee_byte_t rx_byte,
    input  logic     ack_in
);

    seq_state_e state;
    ee_req_t    cur;        // request being served
    ee_byte_t   rdata_q;
    logic       nack_q;
    logic       pending;    // bit op issued, waiting for bit_done
    logic [6:0] ctrl_hi;

    // next state once a written byte was acknowledged
    function automatic seq_state_e after_ack(seq_state_e s, ee_op_e op);
        seq_state_e n;
        case (s)
            SEQ_CTRL_WR: n = SEQ_ADDR_WR;
            SEQ_ADDR_WR: n = (op == OP_WRITE) ? SEQ_DATA_WR : SEQ_READ_START;
            SEQ_CTRL_RD: n = SEQ_DATA_RD;
            default:     n = SEQ_STOP;
        endcase
        return n;
    endfunction

    // device code plus block select, r/w bit appended per state
    assign ctrl_hi = {DEV_CODE, cur.addr[10:8]};

    assign busy      = (state != SEQ_IDLE) && (state != SEQ_DONE);
    assign rsp_valid = (state == SEQ_DONE);
    assign bit_valid = busy & ~pending;

    assign rsp.rdata = rdata_q;
    assign rsp.nack  = nack_q;

    always_comb begin
        bit_req.cmd = BIT_START;
        bit_req.tx  = '0;
        bit_req.ack = 1'b0;   // single byte read, master nacks
        case (state)
            SEQ_CTRL_WR: begin
                bit_req.cmd = BIT_WRITE;
                bit_req.tx  = {ctrl_hi, 1'b0};
            end
            SEQ_ADDR_WR: begin
                bit_req.cmd = BIT_WRITE;
                bit_req.tx  = cur.addr[7:0];
            end
            SEQ_DATA_WR: begin
                bit_req.cmd = BIT_WRITE;
                bit_req.tx  = cur.wdata;
            end
            SEQ_CTRL_RD: begin
                bit_req.cmd = BIT_WRITE;
                bit_req.tx  = {ctrl_hi, 1'b1};
            end
            SEQ_DATA_RD: begin
                bit_req.cmd = BIT_READ;
            end
            SEQ_STOP: begin
                bit_req.cmd = BIT_STOP;
            end
            default: begin
                bit_req.cmd = BIT_START;   // start and repeated start
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (req_valid && state == SEQ_IDLE) begin
            cur <= req;
        end
        if (state == SEQ_DATA_RD && bit_done) begin
            rdata_q <= rx_byte;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= SEQ_IDLE;
            pending <= 1'b0;
            nack_q  <= 1'b0;
        end else begin
            if (bit_valid) begin
                pending <= 1'b1;
            end else if (bit_done) begin
                pending <= 1'b0;
            end
            case (state)
                SEQ_IDLE: begin
                    if (req_valid) begin
                        state  <= SEQ_START;
                        nack_q <= 1'b0;
                    end
                end
                SEQ_START: begin
                    if (bit_done) begin
                        state <= SEQ_CTRL_WR;
                    end
                end
                SEQ_CTRL_WR, SEQ_ADDR_WR, SEQ_DATA_WR, SEQ_CTRL_RD: begin
                    if (bit_done) begin
                        if (!ack_in) begin
                            nack_q <= 1'b1;   // no ack, straight to stop
                            state  <= SEQ_STOP;
                        end else begin
                            state <= after_ack(state, cur.op);
                        end
                    end
                end
                SEQ_READ_START: begin
                    if (bit_done) begin
                        state <= SEQ_CTRL_RD;
                    end
                end
                SEQ_DATA_RD: begin
                    if (bit_done) begin
                        state <= SEQ_STOP;
                    end
                end
                SEQ_STOP: begin
                    if (bit_done) begin
                        state <= SEQ_DONE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;   // done lasts one cycle
                end
            endcase
        end
    end

endmodule

// ==== hw/eeprom_bit_engine.sv ====
`timescale 1ns/10ps

module eeprom_bit_engine import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     bit_valid,
    input  bit_req_t bit_req,
    output logic     bit_done,
    output ee_byte_t rx_byte,
    output logic     ack_in,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    localparam int QW = $clog2(CLK_DIV);

    typedef enum logic [2:0] {
        E_IDLE,
        E_START,
        E_SHOUT,
        E_SHIN,
        E_STOP
    } eng_state_e;

    eng_state_e    state;
    logic [QW-1:0] qcnt;
    logic [1:0]    ph;      // quarter inside the bit slot
    logic [3:0]    nbit;    // slot inside a byte, 8 is the ack slot
    ee_byte_t      sh;
    logic          mack;
    logic          tick;
    logic          last;

    assign tick    = (state != E_IDLE) && (qcnt == QW'(CLK_DIV - 1));
    assign last    = (state == E_START) || (state == E_STOP) || (nbit == 4'd8);
    assign rx_byte = sh;

    // slot: q0 scl low + sda update, q1/q2 scl high, q3 scl low
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= E_IDLE;
            qcnt     <= '0;
            ph       <= '0;
            nbit     <= '0;
            bit_done <= 1'b0;
            ack_in   <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (state == E_IDLE) begin
                if (bit_valid) begin
                    qcnt <= '0;
                    ph   <= 2'd0;
                    nbit <= 4'd0;
                    sh   <= bit_req.tx;
                    mack <= bit_req.ack;
                    case (bit_req.cmd)
                        BIT_START: begin
                            state  <= E_START;
                            sda_oe <= 1'b0;   // scl untouched, high when bus idle
                        end
                        BIT_STOP: begin
                            state  <= E_STOP;
                            scl    <= 1'b0;
                            sda_oe <= 1'b1;
                        end
                        BIT_WRITE: begin
                            state  <= E_SHOUT;
                            scl    <= 1'b0;
                            sda_oe <= ~bit_req.tx[7];   // msb first
                        end
                        default: begin
                            state  <= E_SHIN;
                            scl    <= 1'b0;
                            sda_oe <= 1'b0;
                        end
                    endcase
                end
            end else begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick) begin
                    ph <= ph + 2'd1;
                    case (ph)
                        2'd0: begin
                            scl <= 1'b1;
                        end
                        2'd1: begin
                            // middle of scl high
                            if (state == E_START) begin
                                sda_oe <= 1'b1;
                            end else if (state == E_STOP) begin
                                sda_oe <= 1'b0;
                            end else if (state == E_SHOUT && nbit == 4'd8) begin
                                ack_in <= ~sda_in;
                            end else if (state == E_SHIN && nbit != 4'd8) begin
                                sh <= {sh[6:0], sda_in};
                            end
                        end
                        2'd2: begin
                            if (state != E_STOP) begin
                                scl <= 1'b0;   // stop leaves the bus high
                            end
                        end
                        default: begin
                            if (last) begin
                                state    <= E_IDLE;
                                bit_done <= 1'b1;
                            end else begin
                                nbit <= nbit + 4'd1;
                                if (state == E_SHOUT) begin
                                    sh     <= {sh[6:0], 1'b0};
                                    sda_oe <= (nbit == 4'd7) ? 1'b0 : ~sh[6];
                                end else begin
                                    sda_oe <= (nbit == 4'd7) ? mack : 1'b0;
                                end
                            end
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== hw/eeprom_ctrl_top.sv ====
`timescale 1ns/10ps

module eeprom_ctrl_top import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4   // clk cycles per quarter scl period, >= 2
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);

    ee_req_t  req;
    ee_rsp_t  rsp;
    bit_req_t bit_req;
    ee_byte_t rx_byte;
    logic     req_valid;
    logic     busy;
    logic     rsp_valid;
    logic     bit_valid;
    logic     bit_done;
    logic     ack_in;

    eeprom_apb_regs i_apb_regs (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    eeprom_seq i_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .bit_valid (bit_valid),
        .bit_req   (bit_req),
        .bit_done  (bit_done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in)
    );

    eeprom_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_bit_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .bit_valid (bit_valid),
        .bit_req   (bit_req),
        .bit_done  (bit_done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

// ==== bench/eeprom_model.sv ====
`timescale 1ns/10ps

module eeprom_model import eeprom_pkg::*; (
    input  logic scl,
    inout  wire  sda,
    input  logic absent     // 1 makes the device ignore the bus
);

    typedef enum {M_IDLE, M_RX, M_TX} mode_e;

    logic [7:0]  mem [0:2047];
    mode_e       mode;
    int          bit_cnt;
    int          byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  txb;
    logic [10:0] ptr;       // current address counter
    logic [7:0]  wbuf;
    logic        have_data;
    logic        ack_slot;
    logic        go_tx;
    logic        drive_low;

    assign sda = (drive_low && !absent) ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hFF;
        end
        mode      = M_IDLE;
        ptr       = '0;
        have_data = 1'b0;
        ack_slot  = 1'b0;
        go_tx     = 1'b0;
        drive_low = 1'b0;
    end

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1 && !absent) begin
            mode      = M_RX;
            bit_cnt   = 0;
            byte_idx  = 0;
            ack_slot  = 1'b0;
            go_tx     = 1'b0;
            have_data = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            if (have_data) begin
                mem[ptr] = wbuf;   // byte write commits on stop
            end
            have_data = 1'b0;
            mode      = M_IDLE;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (mode == M_RX && !ack_slot && bit_cnt < 8) begin
            shreg = {shreg[6:0], sda};
            bit_cnt++;
        end else if (mode == M_TX && ack_slot) begin
            if (sda === 1'b0) begin
                ptr   = ptr + 1'b1;
                go_tx = 1'b1;
            end else begin
                mode = M_IDLE;   // master nack ends the read
            end
        end
    end

    always @(negedge scl) begin
        logic ack;
        if (ack_slot) begin
            ack_slot  = 1'b0;
            drive_low = 1'b0;
            if (go_tx) begin
                go_tx     = 1'b0;
                mode      = M_TX;
                txb       = mem[ptr];
                drive_low = ~txb[7];
                bit_cnt   = 1;
            end
        end else if (mode == M_RX && bit_cnt == 8) begin
            bit_cnt = 0;
            ack     = 1'b1;
            case (byte_idx)
                0: begin
                    if (shreg[7:4] != DEV_CODE) begin
                        ack = 1'b0;
                    end else if (shreg[0]) begin
                        ptr   = {shreg[3:1], ptr[7:0]};
                        go_tx = 1'b1;
                    end else begin
                        ptr[10:8] = shreg[3:1];
                    end
                end
                1: ptr[7:0] = shreg;
                2: begin
                    wbuf      = shreg;
                    have_data = 1'b1;
                end
                default: ack = 1'b0;   // no page writes
            endcase
            byte_idx++;
            if (ack) begin
                drive_low = 1'b1;
                ack_slot  = 1'b1;
            end else begin
                mode = M_IDLE;
            end
        end else if (mode == M_TX) begin
            if (bit_cnt < 8) begin
                drive_low = ~txb[7 - bit_cnt];
                bit_cnt++;
            end else begin
                drive_low = 1'b0;   // release for master ack
                ack_slot  = 1'b1;
            end
        end
    end

endmodule

// ==== bench/eeprom_ctrl_assert.sv ====
`timescale 1ns/10ps

module eeprom_ctrl_assert import eeprom_pkg::*; (
    input logic        CLK,
    input logic        RESET,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [31:0] prdata,
    input logic        pready,
    input logic        busy,
    input logic        rsp_valid,
    input logic        scl,
    input logic        sda_oe,
    input logic        sda_in,
    input seq_state_e  state
);

    int fail_cnt = 0;

    // every access phase ends at once with a known read value
    a_pready: assert property (@(posedge CLK) disable iff (RESET)
        (psel && penable) |-> (pready && (pwrite || !$isunknown(prdata))))
        else begin
            $error("apb access not completed in one cycle with known read data");
            fail_cnt++;
        end

    // bus parked while idle
    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> (scl && !sda_oe))
        else begin
            $error("bus not idle while controller not busy");
            fail_cnt++;
        end

    a_sda_framing: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_in))
            |-> (state inside {SEQ_START, SEQ_READ_START, SEQ_STOP}))
        else begin
            $error("sda changed during scl high outside start or stop");
            fail_cnt++;
        end

    // busy falls exactly when the one-cycle response comes
    a_busy_rsp: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid == $fell(busy))
        else begin
            $error("rsp_valid not aligned with the falling edge of busy");
            fail_cnt++;
        end

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assert i_ctrl_assert (
    .CLK       (CLK),
    .RESET     (RESET),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .prdata    (prdata),
    .pready    (pready),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .sda_in    (sda_in),
    .state     (i_seq.state)
);

// ==== bench/tb_eeprom_ctrl.sv ====
`timescale 1ns/10ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int CLK_DIV   = 4;
    localparam int N_TXN     = 24;
    localparam int WD_CYCLES = N_TXN * 39 * 4 * CLK_DIV * 2;

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        sda_oe;
    logic        absent;
    tri1         sda;
    int          errors = 0;
    ee_byte_t    shadow [0:2047];
    bit          written [0:2047];
    ee_addr_t    used [$];

    assign sda = sda_oe ? 1'b0 : 1'bz;   // open drain

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) i_eeprom_ctrl_top (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    eeprom_model i_model (
        .scl    (scl),
        .sda    (sda),
        .absent (absent)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic void check_val(string name, logic [31:0] act, logic [31:0] exp);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endfunction

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);   // middle of access phase
        rdata = prdata;
        err   = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val("pslverr", err, exp_err);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_val("pslverr", err, exp_err);
    endtask

    // poll until busy low and done high
    task automatic wait_done(output logic [31:0] st);
        do begin
            read_reg(REG_STATUS, st, 1'b0);
        end while (st[0] || !st[1]);
    endtask

    task automatic store_byte(input ee_addr_t addr, input ee_byte_t data, input logic exp_nack);
        logic [31:0] st;
        write_reg(REG_ADDR, addr, 1'b0);
        write_reg(REG_WDATA, data, 1'b0);
        write_reg(REG_CMD, 32'h1, 1'b0);
        wait_done(st);
        check_val("status.nack", st[2], exp_nack);
        if (!exp_nack) begin
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end
    endtask

    task automatic verify_byte(input ee_addr_t addr);
        logic [31:0] st;
        logic [31:0] rd;
        write_reg(REG_ADDR, addr, 1'b0);
        write_reg(REG_CMD, 32'h2, 1'b0);
        wait_done(st);
        check_val("status.nack", st[2], 1'b0);
        read_reg(REG_RDATA, rd, 1'b0);
        check_val("rdata", rd, shadow[addr]);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] st;
        ee_addr_t    a;
        ee_byte_t    v;
        void'($urandom(32'hc57d487c));
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = 8'hFF;
        end
        RESET   <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        absent  <= 1'b0;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_val("scl", scl, 1'b1);
        check_val("sda_oe", sda_oe, 1'b0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_val("status", rd, 32'h0);

        // one write per block, then read all back
        for (int b = 0; b < 8; b++) begin
            a = {3'(b), 8'($urandom)};
            store_byte(a, 8'($urandom), 1'b0);
            used.push_back(a);
        end
        foreach (used[i]) begin
            verify_byte(used[i]);
        end

        do begin
            a = 11'($urandom);
        end while (written[a]);
        verify_byte(a);   // erased value

        a = used[0];
        @(posedge CLK);
        absent <= 1'b1;
        store_byte(a, ~shadow[a], 1'b1);
        @(posedge CLK);
        absent <= 1'b0;
        verify_byte(a);

        // command while a write is in flight
        a = {3'd5, 8'($urandom)};
        v = 8'($urandom);
        write_reg(REG_ADDR, a, 1'b0);
        write_reg(REG_WDATA, v, 1'b0);
        write_reg(REG_CMD, 32'h1, 1'b0);
        write_reg(REG_CMD, 32'h2, 1'b1);
        wait_done(st);
        check_val("status.nack", st[2], 1'b0);
        shadow[a]  = v;
        written[a] = 1'b1;
        verify_byte(a);
        write_reg(8'h14, 32'h5a, 1'b1);
        read_reg(8'h14, rd, 1'b1);

        $display("errors: data %0d, protocol %0d", errors,
                 i_eeprom_ctrl_top.i_ctrl_assert.fail_cnt);
        if (errors == 0 && i_eeprom_ctrl_top.i_ctrl_assert.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge CLK);
        $display("watchdog expired after %0d cycles, a transaction never completed", WD_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/eeprom_pkg.sv
hw/eeprom_apb_regs.sv
hw/eeprom_seq.sv
hw/eeprom_bit_engine.sv
hw/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/eeprom_ctrl_assert.sv
bench/tb_eeprom_ctrl.sv

// ==== Bender.yml ====
package:
  name: eeprom_ctrl

sources:
  - hw/eeprom_pkg.sv
  - hw/eeprom_apb_regs.sv
  - hw/eeprom_seq.sv
  - hw/eeprom_bit_engine.sv
  - hw/eeprom_ctrl_top.sv
  - target: simulation
    files:
      - bench/eeprom_model.sv
      - bench/eeprom_ctrl_assert.sv
      - bench/tb_eeprom_ctrl.sv
